// File: tb.f
+incdir+include
src/simd_pkg.sv
src/simd_regfile.sv
src/simd_valu.sv
src/simd_control.sv
src/simd_core.sv
dv/simd_core_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, then run; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module simd_core_tb -o simd_core_tb
./obj_dir/simd_core_tb

// File: include/simd_tb_checks.svh
`ifndef simd_tb_checks_svh
`define simd_tb_checks_svh

// xorshift32 step on rng_state.
function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

task automatic check_idle(input simd_pkg::simd_res_t actual);
	if (actual.valid !== 1'b0)
	begin
		$display("Error at %0t: res.valid expected 0, got %b", $time, actual.valid);
		fail_run("a write-back appeared where none was expected");
	end
endtask

task automatic check_res(input simd_pkg::simd_res_t expected,
	input simd_pkg::simd_res_t actual);
	if (actual.valid !== 1'b1)
	begin
		$display("Error at %0t: res.valid expected 1, got %b", $time, actual.valid);
		fail_run("an expected write-back did not appear");
	end
	else if (actual.dest !== expected.dest)
	begin
		$display("Error at %0t: res.dest expected %0d, got %0d", $time,
			expected.dest, actual.dest);
		fail_run("the write-back named the wrong register");
	end
	else if (actual.data !== expected.data)
	begin
		$display("Error at %0t: res.data expected %h, got %h", $time,
			expected.data, actual.data);
		fail_run("the write-back carried the wrong value");
	end
endtask

`endif

// File: dv/simd_core_tb.sv
`timescale 1ns/1ps

module simd_core_tb;

	localparam int max_cycles = 600; // about 475 cycles of tests plus margin.

	logic clk;
	logic rst_n;
	logic instr_valid;
	simd_pkg::simd_instr_u instr;
	simd_pkg::simd_res_t res;

	logic [simd_pkg::vec_bits-1:0] shadow [simd_pkg::num_regs]; // model of the register file.
	simd_pkg::simd_res_t exp_q [$];
	simd_pkg::simd_res_t exp_now;
	logic [31:0] rng_state = 32'd29903;
	int cycle_count = 0;
	logic [4:0] prev_rd = 5'd12;

	task automatic fail_run(input string why);
		$display("Done: errors found");
		$fatal(1, "%s", why);
	endtask

	`include "simd_tb_checks.svh"

	simd_core u_simd_core
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.res(res)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// natural-width add or subtract per lane, wrapping in each lane.
	function automatic logic [simd_pkg::vec_bits-1:0] lane_arith(input logic [127:0] a,
		input logic [127:0] b, input logic sub, input logic [1:0] width);
		logic [simd_pkg::vec_bits-1:0] y;
		y = '0;
		case (width)
			2'd0:
				for (int i = 0; i < 16; i++)
					y[8*i +: 8] = sub ? a[8*i +: 8] - b[8*i +: 8] : a[8*i +: 8] + b[8*i +: 8];
			2'd1:
				for (int i = 0; i < 8; i++)
					y[16*i +: 16] = sub ? a[16*i +: 16] - b[16*i +: 16] :
						a[16*i +: 16] + b[16*i +: 16];
			default:
				for (int i = 0; i < 4; i++)
					y[32*i +: 32] = sub ? a[32*i +: 32] - b[32*i +: 32] :
						a[32*i +: 32] + b[32*i +: 32];
		endcase
		return y;
	endfunction

	function automatic simd_pkg::simd_res_t ref_result(input logic valid,
		input simd_pkg::simd_instr_u ins);
		simd_pkg::simd_res_t r;
		logic [simd_pkg::vec_bits-1:0] a;
		logic [simd_pkg::vec_bits-1:0] b;
		a = shadow[ins.rform.ra];
		b = shadow[ins.rform.rb];
		r.valid = valid;
		r.dest = ins.rform.rd;
		r.data = '0;
		case (ins.rform.opcode)
			simd_pkg::op_add:
				r.data = lane_arith(a, b, 1'b0, ins.rform.width);
			simd_pkg::op_sub:
				r.data = lane_arith(a, b, 1'b1, ins.rform.width);
			simd_pkg::op_and:
				r.data = a & b;
			simd_pkg::op_or:
				r.data = a | b;
			simd_pkg::op_xor:
				r.data = a ^ b;
			simd_pkg::op_insb:
				r.data[7:0] = a[8*ins.rform.lane +: 8]; // one byte, zero-extended.
			simd_pkg::op_ldi:
				r.data = {8{ins.iform.imm}};
			default:
				r.valid = 1'b0; // nop and undefined codes write nothing.
		endcase
		return r;
	endfunction

	function automatic simd_pkg::simd_instr_u reg_form(input logic [3:0] op,
		input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
		input logic [1:0] width, input logic [3:0] lane);
		simd_pkg::simd_instr_u w;
		w = {op, rd, ra, rb, width, lane, 7'd0};
		return w;
	endfunction

	function automatic simd_pkg::simd_instr_u imm_form(input logic [4:0] rd,
		input logic [15:0] imm);
		simd_pkg::simd_instr_u w;
		w = {simd_pkg::op_ldi, rd, imm, 7'd0};
		return w;
	endfunction

	// one cycle of stimulus and its expected write-back.
	task automatic issue(input logic valid, input simd_pkg::simd_instr_u ins);
		simd_pkg::simd_res_t expected;
		@(posedge clk);
		instr_valid <= valid;
		instr <= ins;
		expected = ref_result(valid, ins);
		if (expected.valid)
			shadow[expected.dest] = expected.data;
		exp_q.push_back(expected);
	endtask

	// sources lean toward the previous destination.
	task automatic random_stream(input int count);
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0] op;
		logic [4:0] ra;
		logic [4:0] rb;
		for (int n = 0; n < count; n++)
		begin
			r = next_random();
			r2 = next_random();
			op = (r[3:0] == 4'hf) ? {1'b1, r[6:4]} : {1'b0, r[6:4]};
			ra = r[8] ? prev_rd : r[13:9];
			rb = r[14] ? prev_rd : r[19:15];
			issue(r2[31:28] != 4'd0, (op == simd_pkg::op_ldi) ? imm_form(r[24:20], r2[15:0]) :
				reg_form(op, r[24:20], ra, rb, (r2[17:16] == 2'd3) ? 2'd0 : r2[17:16], r2[21:18]));
			prev_rd = r[24:20];
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		for (int i = 0; i < 3; i++)
			issue(1'b0, '0);
		rst_n <= 1'b1;
		issue(1'b0, '0);
		issue(1'b1, reg_form(simd_pkg::op_nop, 5'd1, 5'd2, 5'd3, 2'd0, 4'd0));
		issue(1'b1, reg_form(4'hb, 5'd1, 5'd2, 5'd3, 2'd0, 4'd0)); // undefined code.
		for (int k = 0; k < simd_pkg::num_regs; k++)
		begin
			rnd = next_random();
			issue(1'b1, imm_form(5'(k), (k == 1) ? 16'hffff : (k == 2) ? 16'h0001 :
				(k == 3) ? 16'h8000 : rnd[15:0]));
		end
		// all-ones lanes against small and sign-bit values, at every width.
		for (int w = 0; w < 3; w++)
		begin
			issue(1'b1, reg_form(simd_pkg::op_add, 5'(20 + 4*w), 5'd1, 5'd2, 2'(w), 4'd0));
			issue(1'b1, reg_form(simd_pkg::op_add, 5'(21 + 4*w), 5'd1, 5'd1, 2'(w), 4'd0));
			issue(1'b1, reg_form(simd_pkg::op_sub, 5'(22 + 4*w), 5'd2, 5'd1, 2'(w), 4'd0));
			issue(1'b1, reg_form(simd_pkg::op_sub, 5'(23 + 4*w), 5'd3, 5'd2, 2'(w), 4'd0));
		end
		issue(1'b1, reg_form(simd_pkg::op_and, 5'd10, 5'd5, 5'd6, 2'd0, 4'd0));
		issue(1'b1, reg_form(simd_pkg::op_or, 5'd11, 5'd7, 5'd8, 2'd0, 4'd0));
		issue(1'b1, reg_form(simd_pkg::op_xor, 5'd12, 5'd1, 5'd9, 2'd0, 4'd0));
		random_stream(400);
		for (int l = 0; l < 16; l++)
			issue(1'b1, reg_form(simd_pkg::op_insb, 5'(16 + l), 5'd9, 5'd0, 2'd0, 4'(l)));
		issue(1'b0, '0);
		issue(1'b0, '0);
		@(posedge clk);
		$display("Done: no errors");
		$finish;
	end

	// a result is due at the falling edge two rising edges after it was driven.
	always @(negedge clk)
	begin
		if (!rst_n && cycle_count > 0)
			check_idle(res); // reset holds the write-back low.
		if (exp_q.size() > 2)
		begin
			exp_now = exp_q.pop_front();
			if (exp_now.valid)
				check_res(exp_now, res);
			else
				check_idle(res);
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
			fail_run("timeout: the run did not finish within the cycle limit");
	end

endmodule

// File: src/simd_core.sv
`timescale 1ns/1ps

module simd_core
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input simd_pkg::simd_instr_u instr,
	output simd_pkg::simd_res_t res
);

	logic rd1en;
	logic rd2en;
	logic [4:0] rd1addr;
	logic [4:0] rd2addr;
	logic [simd_pkg::vec_bits-1:0] rd1data;
	logic [simd_pkg::vec_bits-1:0] rd2data;
	logic [simd_pkg::vec_bits-1:0] alu_result;
	simd_pkg::simd_opcode_e alu_opcode;
	simd_pkg::simd_width_e alu_width;
	logic [15:0] alu_imm;
	simd_pkg::simd_wr_t wr;

	simd_control u_control
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.alu_result(alu_result),
		.rd1en(rd1en),
		.rd2en(rd2en),
		.rd1addr(rd1addr),
		.rd2addr(rd2addr),
		.alu_opcode(alu_opcode),
		.alu_width(alu_width),
		.alu_imm(alu_imm),
		.wr(wr)
	);

	simd_regfile u_regfile
	(
		.clk(clk),
		.rst_n(rst_n),
		.rd1en(rd1en),
		.rd2en(rd2en),
		.rd1addr(rd1addr),
		.rd2addr(rd2addr),
		.wr(wr),
		.rd1data(rd1data),
		.rd2data(rd2data),
		.res(res)
	);

	simd_valu u_valu
	(
		.opcode(alu_opcode),
		.width(alu_width),
		.a(rd1data),
		.b(rd2data),
		.imm(alu_imm),
		.result(alu_result)
	);

endmodule

// File: src/simd_control.sv
`timescale 1ns/1ps

module simd_control
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input simd_pkg::simd_instr_u instr,
	input logic [simd_pkg::vec_bits-1:0] alu_result,
	output logic rd1en,
	output logic rd2en,
	output logic [4:0] rd1addr,
	output logic [4:0] rd2addr,
	output simd_pkg::simd_opcode_e alu_opcode,
	output simd_pkg::simd_width_e alu_width,
	output logic [15:0] alu_imm,
	output simd_pkg::simd_wr_t wr
);

	typedef struct packed
	{
		simd_pkg::simd_opcode_e opcode;
		simd_pkg::simd_width_e width;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [simd_pkg::num_lanes-1:0] mask;
	} ex_t;

	simd_pkg::simd_opcode_e dec_op;
	ex_t dec;
	ex_t ex;
	logic ex_valid;

	// undefined codes fall back to nop.
	always_comb
	begin
		case (instr.rform.opcode)
			simd_pkg::op_add,
			simd_pkg::op_sub,
			simd_pkg::op_and,
			simd_pkg::op_or,
			simd_pkg::op_xor,
			simd_pkg::op_insb,
			simd_pkg::op_ldi:
				dec_op = instr.rform.opcode;
			default:
				dec_op = simd_pkg::op_nop;
		endcase
	end

	always_comb
	begin
		dec.opcode = dec_op;
		dec.width = instr.rform.width;
		if (dec_op == simd_pkg::op_ldi)
		begin
			dec.rd = instr.iform.rd;
			dec.imm = instr.iform.imm;
		end
		else
		begin
			dec.rd = instr.rform.rd;
			dec.imm = '0;
		end
		for (int k = 0; k < simd_pkg::num_lanes; k++)
			dec.mask[k] = (k <= int'(instr.rform.lane)); // thermometer up to lane.
	end

	// operand reads are issued in the sampling cycle.
	always_comb
	begin
		rd1en = 1'b0;
		rd2en = 1'b0;
		rd1addr = instr.rform.ra;
		rd2addr = instr.rform.rb;
		if (instr_valid)
		begin
			case (dec_op)
				simd_pkg::op_add,
				simd_pkg::op_sub,
				simd_pkg::op_and,
				simd_pkg::op_or,
				simd_pkg::op_xor:
				begin
					rd1en = 1'b1;
					rd2en = 1'b1;
				end
				simd_pkg::op_insb:
					rd1en = 1'b1;
				default:
				begin
					rd1en = 1'b0;
					rd2en = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= instr_valid;
	end

	always_ff @(posedge clk)
	begin
		ex <= dec;
	end

	assign alu_opcode = ex.opcode;
	assign alu_width = ex.width;
	assign alu_imm = ex.imm;

	always_comb
	begin
		wr.en = ex_valid && (ex.opcode != simd_pkg::op_nop);
		wr.addr = ex.rd;
		wr.byte_en = (ex.opcode == simd_pkg::op_insb) ? ex.mask : '0;
		wr.data = alu_result;
	end

endmodule

// File: src/simd_valu.sv
`timescale 1ns/1ps

module simd_valu
(
	input simd_pkg::simd_opcode_e opcode,
	input simd_pkg::simd_width_e width,
	input logic [simd_pkg::vec_bits-1:0] a,
	input logic [simd_pkg::vec_bits-1:0] b,
	input logic [15:0] imm,
	output logic [simd_pkg::vec_bits-1:0] result
);

	logic is_sub;
	logic [simd_pkg::vec_bits-1:0] b_op;
	logic [simd_pkg::vec_bits-1:0] arith;
	logic [1:0] lane_mask;

	assign is_sub = (opcode == simd_pkg::op_sub);
	assign b_op = is_sub ? ~b : b; // a - b as a + ~b + 1.

	// byte index bits that stay inside one lane.
	always_comb
	begin
		case (width)
			simd_pkg::w_byte:
				lane_mask = 2'b00;
			simd_pkg::w_half:
				lane_mask = 2'b01;
			default:
				lane_mask = 2'b11;
		endcase
	end

	// byte-sliced adder, the carry restarts at every lane boundary.
	always_comb
	begin
		logic carry;
		logic [8:0] byte_sum;
		carry = 1'b0;
		byte_sum = '0;
		arith = '0;
		for (int k = 0; k < simd_pkg::num_lanes; k++)
		begin
			if ((2'(k) & lane_mask) == 2'b00)
				carry = is_sub; // first byte of a lane.
			byte_sum = {1'b0, a[8*k +: 8]} + {1'b0, b_op[8*k +: 8]} + {8'd0, carry};
			arith[8*k +: 8] = byte_sum[7:0];
			carry = byte_sum[8];
		end
	end

	always_comb
	begin
		case (opcode)
			simd_pkg::op_add,
			simd_pkg::op_sub:
				result = arith;
			simd_pkg::op_and:
				result = a & b;
			simd_pkg::op_or:
				result = a | b;
			simd_pkg::op_xor:
				result = a ^ b;
			simd_pkg::op_insb:
				result = a; // the register file picks the byte.
			simd_pkg::op_ldi:
				result = {(simd_pkg::vec_bits/16){imm}};
			default:
				result = '0;
		endcase
	end

endmodule

// File: src/simd_regfile.sv
`timescale 1ns/1ps

module simd_regfile
(
	input logic clk,
	input logic rst_n,
	input logic rd1en,
	input logic rd2en,
	input logic [4:0] rd1addr,
	input logic [4:0] rd2addr,
	input simd_pkg::simd_wr_t wr,
	output logic [simd_pkg::vec_bits-1:0] rd1data,
	output logic [simd_pkg::vec_bits-1:0] rd2data,
	output simd_pkg::simd_res_t res
);

	logic [simd_pkg::vec_bits-1:0] mem [simd_pkg::num_regs];
	logic wr_full;
	logic wr_therm;
	logic wr_do;
	logic [3:0] wr_lane;
	logic [simd_pkg::vec_bits-1:0] wr_value;
	logic res_valid_q;
	logic [4:0] res_dest_q;
	logic [simd_pkg::vec_bits-1:0] res_data_q;

	always_comb
	begin
		wr_full = (wr.byte_en == '0);
		wr_therm = !wr_full && ((wr.byte_en & (wr.byte_en + 1'b1)) == '0); // 0..01..1 only.
		wr_lane = 4'd0;
		for (int k = 0; k < simd_pkg::num_lanes; k++)
		begin
			if (wr.byte_en[k])
				wr_lane = 4'(k); // highest set bit wins.
		end
		wr_do = wr.en && (wr_full || wr_therm);
		if (wr_full)
			wr_value = wr.data;
		else
		begin
			wr_value = '0;
			wr_value[7:0] = wr.data[8*wr_lane +: 8]; // picked byte, zero-extended.
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_do)
			mem[wr.addr] <= wr_value;
		if (rd1en)
			rd1data <= (wr_do && wr.addr == rd1addr) ? wr_value : mem[rd1addr]; // write-through.
		if (rd2en)
			rd2data <= (wr_do && wr.addr == rd2addr) ? wr_value : mem[rd2addr];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			res_valid_q <= 1'b0;
		else
			res_valid_q <= wr_do;
	end

	always_ff @(posedge clk)
	begin
		if (wr_do)
		begin
			res_dest_q <= wr.addr;
			res_data_q <= wr_value;
		end
	end

	assign res = '{valid: res_valid_q, dest: res_dest_q, data: res_data_q};

endmodule

// File: src/simd_pkg.sv
package simd_pkg;

	localparam int num_regs = 32; // architectural vector registers.
	localparam int vec_bits = 128;
	localparam int num_lanes = 16; // byte lanes per vector.

	typedef enum logic [3:0]
	{
		op_nop = 4'd0,
		op_add = 4'd1,
		op_sub = 4'd2,
		op_and = 4'd3,
		op_or = 4'd4,
		op_xor = 4'd5,
		op_insb = 4'd6,
		op_ldi = 4'd7
	} simd_opcode_e;

	typedef enum logic [1:0]
	{
		w_byte = 2'd0,
		w_half = 2'd1,
		w_word = 2'd2
	} simd_width_e;

	// three-operand register form.
	typedef struct packed
	{
		simd_opcode_e opcode;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		simd_width_e width;
		logic [3:0] lane;
		logic [6:0] pad;
	} simd_rform_t;

	// immediate form, opcode and rd sit where the register form has them.
	typedef struct packed
	{
		simd_opcode_e opcode;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [6:0] pad;
	} simd_iform_t;

	typedef union packed
	{
		simd_rform_t rform;
		simd_iform_t iform;
	} simd_instr_u;

	typedef struct packed
	{
		logic en;
		logic [4:0] addr;
		logic [num_lanes-1:0] byte_en; // zero is a full write.
		logic [vec_bits-1:0] data;
	} simd_wr_t;

	typedef struct packed
	{
		logic valid;
		logic [4:0] dest;
		logic [vec_bits-1:0] data;
	} simd_res_t;

endpackage
